/* nes_video.f */
nes_video_pkg.sv
tile_row_if.sv
video_ram.sv
tile_fetch.sv
row_fifo.sv
pixel_shifter.sv
nes_video.sv
nes_video_chk.sv
nes_video_tb.sv

/* nes_video.sv */
`timescale 1ns/1ps

// Background renderer, memories plus fetch, buffer and shifter
module nes_video (
    input  logic                clk,
    input  logic                rst,

    // Loader write port, shared by both memories
    input  logic                name_we,
    input  logic                chr_we,
    input  logic [11:0]         wr_addr,
    input  logic [7:0]          wr_data,

    // Control
    input  logic                start,
    output logic                busy,

    // Pixel stream
    output logic                pix_valid,
    output nes_video_pkg::pix_t pix_color,
    output logic                frame_start,
    output logic                frame_done
);

    nes_video_pkg::name_addr_t name_addr;
    nes_video_pkg::chr_addr_t  chr_addr;
    logic [7:0]                name_data;
    logic [7:0]                chr_data;

    tile_row_if fetch_rows ();   // Fetch to FIFO
    tile_row_if shift_rows ();   // FIFO to shifter

    // --------------------------------------------------
    // Memories
    // --------------------------------------------------
    video_ram #(.DEPTH(nes_video_pkg::NAME_BYTES)) name_ram_i (
        .clk   (clk),
        .we    (name_we),
        .waddr (wr_addr[$clog2(nes_video_pkg::NAME_BYTES)-1:0]),  // Upper bits unused
        .wdata (wr_data),
        .raddr (name_addr),
        .rdata (name_data)
    );

    video_ram #(.DEPTH(nes_video_pkg::CHR_BYTES)) chr_ram_i (
        .clk   (clk),
        .we    (chr_we),
        .waddr (wr_addr),
        .wdata (wr_data),
        .raddr (chr_addr),
        .rdata (chr_data)
    );

    // --------------------------------------------------
    // Render pipeline
    // --------------------------------------------------
    tile_fetch tile_fetch_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .frame_done (frame_done),
        .name_addr  (name_addr),
        .name_data  (name_data),
        .chr_addr   (chr_addr),
        .chr_data   (chr_data),
        .rows       (fetch_rows.src)
    );

    row_fifo row_fifo_i (
        .clk (clk),
        .rst (rst),
        .wr  (fetch_rows.fifo_side),
        .rd  (shift_rows.fifo_out)
    );

    pixel_shifter pixel_shifter_i (
        .clk         (clk),
        .rst         (rst),
        .rows        (shift_rows.dst),
        .pix_valid   (pix_valid),
        .pix_color   (pix_color),
        .frame_start (frame_start),
        .frame_done  (frame_done)
    );

endmodule

/* nes_video_chk.sv */
`timescale 1ns/1ps

// FIFO protocol and pixel slot timing properties
module nes_video_chk (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic busy,
    input logic pix_valid,
    input logic frame_start,
    input logic frame_done
);

    logic in_frame;    // After the first pixel, until frame_done
    int   gap;         // Cycles since the previous pixel
    int   rows_held;   // FIFO occupancy rebuilt from the strobes

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame  <= 1'b0;
            gap       <= 0;
            rows_held <= 0;
        end else begin
            if (frame_start) begin
                in_frame <= 1'b1;
            end else if (frame_done) begin
                in_frame <= 1'b0;
            end
            gap       <= pix_valid ? 1 : gap + 1;
            rows_held <= rows_held + int'(push) - int'(pop);   // One row per strobe
        end
    end

    // --------------------------------------------------
    // Properties
    // --------------------------------------------------
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("Row pushed while the FIFO was full");

    // Own occupancy, independent of the FIFO's count
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        rows_held == 0 |-> empty && !pop)
        else $error("Empty flag wrong or row popped from an empty FIFO");

    // Pixel 0 sets in_frame, so spacing is checked from pixel 1 on
    a_pix_spacing: assert property (@(posedge clk) disable iff (rst)
        pix_valid && in_frame && busy |-> gap == nes_video_pkg::PIX_DIV)
        else $error("Pixel strobes not one slot apart");

    a_idle_after_rst: assert property (@(posedge clk) rst |=> !busy)
        else $error("Renderer busy right after reset");

endmodule

bind nes_video nes_video_chk nes_video_chk_i (
    .clk         (clk),
    .rst         (rst),
    .push        (fetch_rows.push),
    .full        (fetch_rows.full),
    .pop         (shift_rows.pop),
    .empty       (shift_rows.empty),
    .busy        (busy),
    .pix_valid   (pix_valid),
    .frame_start (frame_start),
    .frame_done  (frame_done)
);

/* nes_video_pkg.sv */
package nes_video_pkg;

    // --------------------------------------------------
    // Frame geometry
    // --------------------------------------------------
    localparam int TILES_X      = 32;                  // Tiles across
    localparam int TILES_Y      = 30;                  // Tiles down
    localparam int TILE_PX      = 8;                   // Pixels per tile side
    localparam int FRAME_PIXELS = TILES_X * TILES_Y * TILE_PX * TILE_PX;

    // --------------------------------------------------
    // Memory sizes
    // --------------------------------------------------
    localparam int NAME_BYTES = 1024;                  // Name table, one byte per tile
    localparam int CHR_BYTES  = 4096;                  // 256 tiles of 16 bytes

    typedef logic [$clog2(NAME_BYTES)-1:0] name_addr_t;
    typedef logic [$clog2(CHR_BYTES)-1:0]  chr_addr_t;

    // --------------------------------------------------
    // Pixel timing and buffering
    // --------------------------------------------------
    localparam int PIX_DIV    = 4;                     // Clocks per pixel slot
    localparam int FIFO_DEPTH = 4;                     // Pattern rows held

    // 2-bit colour index, high plane in bit 1
    typedef logic [1:0] pix_t;

    // One 8-pixel slice of a tile, both planes
    typedef struct packed {
        logic [7:0] plane_lo;   // Low plane byte
        logic [7:0] plane_hi;   // High plane byte
        logic       first;      // Row that opens the frame
        logic       last;       // Final row of the frame
    } tile_row_t;

endpackage

/* nes_video_tb.sv */
`timescale 1ns/1ps

module nes_video_tb;

    localparam int TIMEOUT_CYCLES = 600000;   // Two frames of ~246k plus loading
    localparam int LINE_PX = nes_video_pkg::TILES_X * nes_video_pkg::TILE_PX;

    logic                clk;
    logic                rst;
    logic                name_we;
    logic                chr_we;
    logic [11:0]         wr_addr;
    logic [7:0]          wr_data;
    logic                start;
    logic                busy;
    logic                pix_valid;
    nes_video_pkg::pix_t pix_color;
    logic                frame_start;
    logic                frame_done;

    logic [7:0] name_mirror [nes_video_pkg::NAME_BYTES];   // Copies of both memories
    logic [7:0] chr_mirror  [nes_video_pkg::CHR_BYTES];

    integer seed;
    int     cycles;     // Timeout counter
    int     pix_cnt;    // Pixels seen in the current frame
    int     gap;        // Cycles since the previous pixel
    int     done_cnt;   // Frames completed

    nes_video nes_video_i (.*);

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Reference model and compare tasks
    // --------------------------------------------------
    function automatic nes_video_pkg::pix_t expected_pixel(int x, int y);
        int         tile;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [2:0] sel;
        tile = int'(name_mirror[nes_video_pkg::name_addr_t'((y / 8) * 32 + x / 8)]);
        lo   = chr_mirror[nes_video_pkg::chr_addr_t'(tile * 16 + y % 8)];      // 16 bytes a tile
        hi   = chr_mirror[nes_video_pkg::chr_addr_t'(tile * 16 + 8 + y % 8)];
        sel  = 3'(7 - x % 8);   // Leftmost pixel in bit 7
        return {hi[sel], lo[sel]};
    endfunction

    task automatic check_pixel(string name, nes_video_pkg::pix_t exp, nes_video_pkg::pix_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    task automatic check_flag(string name, bit exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Wrong value on %s", name);
        end
    endtask

    // --------------------------------------------------
    // Loader writes and frame runs
    // --------------------------------------------------
    task automatic write_name(nes_video_pkg::name_addr_t addr, logic [7:0] data);
        @(posedge clk);
        name_we <= 1'b1;
        chr_we  <= 1'b0;
        wr_addr <= 12'(addr);
        wr_data <= data;
        name_mirror[addr] = data;
    endtask

    task automatic write_chr(nes_video_pkg::chr_addr_t addr, logic [7:0] data);
        @(posedge clk);
        name_we <= 1'b0;
        chr_we  <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        chr_mirror[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        name_we <= 1'b0;
        chr_we  <= 1'b0;
    endtask

    task automatic run_frame(int frame_no);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (100) @(posedge clk);
        check_flag("busy", 1'b1, busy);
        start <= 1'b1;   // Mid-frame, must be ignored
        @(posedge clk);
        start <= 1'b0;
        while (done_cnt < frame_no) @(posedge clk);
        repeat (50) @(posedge clk);
        check_flag("busy", 1'b0, busy);   // No extra frame behind it
        check_count("pixels after frame_done", 0, pix_cnt);
    endtask

    // --------------------------------------------------
    // Comparing process, one pixel per strobe
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            pix_cnt = 0;
            gap     = 0;
        end else begin
            gap = gap + 1;
            check_flag("frame_start", pix_valid && pix_cnt == 0, frame_start);
            if (pix_valid) begin
                check_pixel("pix_color", expected_pixel(pix_cnt % LINE_PX, pix_cnt / LINE_PX),
                            pix_color);
                if (pix_cnt > 0) begin
                    check_count("pixel spacing", nes_video_pkg::PIX_DIV, gap);
                end
                pix_cnt = pix_cnt + 1;
                gap     = 0;
            end
            if (frame_done) begin
                check_count("pixels per frame", nes_video_pkg::FRAME_PIXELS, pix_cnt);
                check_flag("busy", 1'b0, busy);   // Falls with frame_done
                done_cnt = done_cnt + 1;
                pix_cnt  = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the frames did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        name_we  = 1'b0;
        chr_we   = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        start    = 1'b0;
        seed     = 34;
        cycles   = 0;
        done_cnt = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Idle after reset
        repeat (20) begin
            @(posedge clk);
            check_flag("busy", 1'b0, busy);
            check_flag("pix_valid", 1'b0, pix_valid);
            check_flag("frame_done", 1'b0, frame_done);
        end

        // Frame 1 from fully random tables
        for (int i = 0; i < nes_video_pkg::NAME_BYTES; i++) begin
            write_name(nes_video_pkg::name_addr_t'(i), 8'($random(seed)));
        end
        for (int i = 0; i < nes_video_pkg::CHR_BYTES; i++) begin
            write_chr(nes_video_pkg::chr_addr_t'(i), 8'($random(seed)));
        end
        end_writes();
        run_frame(1);

        // Frame 2 after a partial rewrite
        for (int i = 0; i < 64; i++) begin
            write_chr(nes_video_pkg::chr_addr_t'($random(seed)), 8'($random(seed)));
        end
        for (int i = 0; i < 32; i++) begin
            write_name(nes_video_pkg::name_addr_t'($random(seed)), 8'($random(seed)));
        end
        end_writes();
        run_frame(2);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* pixel_shifter.sv */
`timescale 1ns/1ps

// Pops pattern rows and shifts out one colour index per pixel slot
module pixel_shifter (
    input  logic                clk,
    input  logic                rst,
    tile_row_if.dst             rows,
    output logic                pix_valid,
    output nes_video_pkg::pix_t pix_color,
    output logic                frame_start,
    output logic                frame_done
);

    localparam int               DIV_W    = $clog2(nes_video_pkg::PIX_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(nes_video_pkg::PIX_DIV - 1);
    localparam logic [3:0]       ROW_BITS = 4'(nes_video_pkg::TILE_PX);

    nes_video_pkg::tile_row_t head;

    logic [7:0]       sh_lo;       // Low plane, MSB first
    logic [7:0]       sh_hi;       // High plane, MSB first
    logic [3:0]       bits_left;   // Pixels still in the registers
    logic [DIV_W-1:0] div;         // Pixel slot divider
    logic [DIV_W-1:0] div_next;
    logic             row_first;
    logic             row_last;
    logic             last_px;     // Frame's final pixel on the output
    logic             load;
    logic             emit;

    assign head     = rows.row_out;
    assign load     = (bits_left == 4'd0) && !rows.empty;
    assign rows.pop = load;
    assign emit     = (div == '0) && (bits_left != 4'd0);
    assign div_next = (div == DIV_LAST) ? '0 : div + 1'b1;

    // --------------------------------------------------
    // Control and markers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            bits_left   <= 4'd0;
            div         <= '0;
            row_first   <= 1'b0;
            row_last    <= 1'b0;
            pix_valid   <= 1'b0;
            frame_start <= 1'b0;
            last_px     <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            pix_valid   <= emit;
            frame_start <= emit && row_first && (bits_left == ROW_BITS);
            last_px     <= emit && row_last && (bits_left == 4'd1);
            frame_done  <= last_px;   // One cycle after the last pixel
            if (load) begin
                bits_left <= ROW_BITS;
                row_first <= head.first;
                row_last  <= head.last;
                // New frame realigns the slots, first pixel next cycle
                div       <= head.first ? '0 : div_next;
            end else begin
                if (emit) begin
                    bits_left <= bits_left - 4'd1;
                end
                div <= div_next;
            end
        end
    end

    // Plane registers and colour out
    always_ff @(posedge clk) begin
        if (load) begin
            sh_lo <= head.plane_lo;
            sh_hi <= head.plane_hi;
        end else if (emit) begin
            sh_lo <= {sh_lo[6:0], 1'b0};
            sh_hi <= {sh_hi[6:0], 1'b0};
        end
        if (emit) begin
            pix_color <= {sh_hi[7], sh_lo[7]};
        end
    end

endmodule

/* row_fifo.sv */
`timescale 1ns/1ps

// Circular buffer of pattern rows, fetch stage to shifter
module row_fifo (
    input  logic          clk,
    input  logic          rst,
    tile_row_if.fifo_side wr,
    tile_row_if.fifo_out  rd
);

    localparam int DEPTH = nes_video_pkg::FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    nes_video_pkg::tile_row_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;     // Rows held, 0..DEPTH
    logic             do_push;
    logic             do_pop;

    // --------------------------------------------------
    // Status
    // --------------------------------------------------
    assign wr.full    = (count == (PTR_W + 1)'(DEPTH));
    assign rd.empty   = (count == '0);
    assign rd.row_out = mem[rd_ptr];   // Head row

    assign do_push = wr.push && !wr.full;
    assign do_pop  = rd.pop && !rd.empty;

    // --------------------------------------------------
    // Pointers and count
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Power-of-two depth, wraps itself
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.row;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module nes_video_tb -f nes_video.f \
    && ./obj_dir/Vnes_video_tb \
    || exit 1

/* tile_fetch.sv */
`timescale 1ns/1ps

// Walks the name table in raster order and pushes pattern rows
module tile_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    output logic                      busy,
    input  logic                      frame_done,  // From the shifter
    output nes_video_pkg::name_addr_t name_addr,
    input  logic [7:0]                name_data,
    output nes_video_pkg::chr_addr_t  chr_addr,
    input  logic [7:0]                chr_data,
    tile_row_if.src                   rows
);

    localparam logic [4:0] LAST_COL = 5'(nes_video_pkg::TILES_X - 1);
    localparam logic [7:0] LAST_ROW =
        8'(nes_video_pkg::TILES_Y * nes_video_pkg::TILE_PX - 1);

    logic       busy_q;      // Frame in progress
    logic       active;      // Still fetching
    logic [1:0] phase;       // 0 name, 1 low, 2 high, 3 push
    logic [4:0] col;         // Tile column
    logic [7:0] scr_row;     // Screen line 0..239
    logic [7:0] tile_idx;    // Name entry of current tile
    logic [7:0] plane_lo;    // Low plane, held for the push
    logic       first_tile;
    logic       last_tile;

    assign first_tile = (col == 5'd0) && (scr_row == 8'd0);
    assign last_tile  = (col == LAST_COL) && (scr_row == LAST_ROW);

    // Drops in the frame_done cycle itself
    assign busy = busy_q & ~frame_done;

    // --------------------------------------------------
    // Memory addressing
    // --------------------------------------------------
    assign name_addr = {scr_row[7:3], col};   // Tile row * 32 + column

    always_comb begin
        if (phase == 2'd1) begin
            chr_addr = {name_data, 1'b0, scr_row[2:0]};   // Low plane, index fresh from RAM
        end else begin
            chr_addr = {tile_idx, 1'b1, scr_row[2:0]};    // High plane, +8
        end
    end

    // --------------------------------------------------
    // Sequencing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            active  <= 1'b0;
            phase   <= 2'd0;
            col     <= 5'd0;
            scr_row <= 8'd0;
        end else begin
            if (start && !busy) begin
                busy_q  <= 1'b1;
                active  <= 1'b1;
                phase   <= 2'd0;
                col     <= 5'd0;
                scr_row <= 8'd0;
            end else begin
                if (frame_done) begin
                    busy_q <= 1'b0;
                end
                if (active) begin
                    // A tile starts only with room in the FIFO
                    if (phase != 2'd0 || !rows.full) begin
                        phase <= phase + 2'd1;   // Wraps after the push
                    end
                    if (phase == 2'd3) begin
                        if (last_tile) begin
                            active <= 1'b0;      // Frame fully fetched
                        end else if (col == LAST_COL) begin
                            col     <= 5'd0;
                            scr_row <= scr_row + 8'd1;
                        end else begin
                            col <= col + 5'd1;
                        end
                    end
                end
            end
        end
    end

    // Tile index and low plane as they come back
    always_ff @(posedge clk) begin
        if (phase == 2'd1) begin
            tile_idx <= name_data;
        end
        if (phase == 2'd2) begin
            plane_lo <= chr_data;
        end
    end

    // --------------------------------------------------
    // Row push
    // --------------------------------------------------
    assign rows.push = active && (phase == 2'd3);
    assign rows.row  = '{plane_lo: plane_lo,
                         plane_hi: chr_data,      // High plane lands this cycle
                         first:    first_tile,
                         last:     last_tile};

endmodule

/* tile_row_if.sv */
`timescale 1ns/1ps

// Pattern row link, push side and pop side share one definition
interface tile_row_if;

    logic                      push;     // Write strobe, no back-pressure
    nes_video_pkg::tile_row_t  row;      // Row being pushed
    logic                      full;     // Checked before each tile
    logic                      pop;      // Removes head row
    logic                      empty;
    nes_video_pkg::tile_row_t  row_out;  // Head row, valid while !empty

    // Producer and FIFO write side
    modport src       (output push, output row, input full);
    modport fifo_side (input push, input row, output full);

    // FIFO read side and consumer
    modport fifo_out  (input pop, output empty, output row_out);
    modport dst       (output pop, input empty, input row_out);

endinterface

/* video_ram.sv */
`timescale 1ns/1ps

// Byte-wide RAM, one write port and one registered read port
module video_ram #(
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [7:0]               wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [7:0]               rdata
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    logic [7:0] mem [DEPTH];

    // Loader side, writes only while the renderer idles
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    // Data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule
